//--- design/pmem_defines.svh
`ifndef PMEM_DEFINES_SVH
`define PMEM_DEFINES_SVH

// Line geometry
`define PMEM_LINE_BITS   256
`define PMEM_OFFSET_BITS 5

// Lines kept by the memory model
`define PMEM_INDEX_BITS  10

// Memory latency in clock cycles
`define PMEM_DELAY       12

`endif

//--- design/pmem_pkg.sv
`default_nettype none

`include "pmem_defines.svh"

package pmem_pkg;

    typedef logic [31:0] addr_t;                            // Byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [`PMEM_LINE_BITS-1:0] line_t;
    typedef logic [31-`PMEM_OFFSET_BITS:0] line_addr_t;     // Byte address without offset
    typedef logic [2:0]  word_sel_t;                        // Word slot within a line

    typedef enum logic [1:0] {
        pmem_idle,
        pmem_busy,
        pmem_fail,
        pmem_respond
    } pmem_state_t;

    typedef enum logic [1:0] {
        client_idle,
        client_wait_read,
        client_wait_write
    } client_state_t;

endpackage

`default_nettype wire

//--- design/phys_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmem_defines.svh"

module phys_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 read,
    input  logic                 write,
    input  pmem_pkg::line_addr_t address,
    input  pmem_pkg::line_t      wdata,
    output logic                 resp,
    output logic                 error,
    output pmem_pkg::line_t      rdata
);
    import pmem_pkg::*;

    localparam int unsigned count_bits = $clog2(`PMEM_DELAY + 1);

    line_t mem_array [0:(1 << `PMEM_INDEX_BITS)-1] = '{default: '0};  // Starts cleared

    pmem_state_t                state;
    logic [count_bits-1:0]      count;
    logic                       cap_read;
    logic                       cap_write;
    line_addr_t                 cap_address;
    line_t                      cap_wdata;
    logic [`PMEM_INDEX_BITS-1:0] index;
    logic                       start;
    logic                       changed;
    logic                       done;

    assign index = cap_address[`PMEM_INDEX_BITS-1:0];
    assign start = (state == pmem_idle) && (read || write);

    // A held request must match what was captured in idle
    assign changed = (address != cap_address) ||
                     (read != cap_read) ||
                     (write != cap_write) ||
                     (cap_write && (wdata != cap_wdata));

    assign done  = (state == pmem_busy) && !changed && (count == '0);
    assign error = (state == pmem_fail);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pmem_idle;
            count <= '0;
            resp  <= 1'b0;
        end else begin
            resp <= done;                                   // One-cycle pulse
            case (state)
                pmem_idle: begin
                    if (start) begin
                        count <= count_bits'(`PMEM_DELAY - 1);
                        state <= pmem_busy;
                    end
                end
                pmem_busy: begin
                    if (changed) begin
                        state <= pmem_fail;
                    end else if (count == '0) begin
                        state <= pmem_respond;
                    end
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end
                end
                pmem_fail: begin
                    if (count == '0) begin
                        state <= pmem_respond;              // Latency expired, no resp
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= pmem_idle;                // Respond cycle ignores requests
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cap_read    <= read;
            cap_write   <= write;
            cap_address <= address;
            cap_wdata   <= wdata;
        end
        if (done) begin
            if (cap_write) begin
                mem_array[index] <= cap_wdata;
                rdata            <= cap_wdata;             // Write returns the new line
            end else begin
                rdata <= mem_array[index];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pmem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module pmem_arbiter (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 fetch_mem_read,
    input  pmem_pkg::line_addr_t fetch_mem_address,
    output logic                 fetch_mem_resp,

    input  logic                 data_mem_read,
    input  logic                 data_mem_write,
    input  pmem_pkg::line_addr_t data_mem_address,
    input  pmem_pkg::line_t      data_mem_wdata,
    output logic                 data_mem_resp,

    output logic                 pmem_read,
    output logic                 pmem_write,
    output pmem_pkg::line_addr_t pmem_address,
    output pmem_pkg::line_t      pmem_wdata,
    input  logic                 pmem_resp
);

    logic busy;
    logic owner;            // 0 fetch, 1 data
    logic last_served;
    logic fetch_req;
    logic data_req;
    logic pick_data;

    assign fetch_req = fetch_mem_read;
    assign data_req  = data_mem_read || data_mem_write;

    // On a tie the client not served last wins
    assign pick_data = data_req && (!fetch_req || !last_served);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            last_served <= 1'b1;
        end else if (busy) begin
            if (pmem_resp) begin
                busy        <= 1'b0;                // Bus free from next cycle
                last_served <= owner;
            end
        end else if (fetch_req || data_req) begin
            busy  <= 1'b1;
            owner <= pick_data;
        end
    end

    assign pmem_read    = busy && (owner ? data_mem_read : fetch_mem_read);
    assign pmem_write   = busy && owner && data_mem_write;   // Only data writes
    assign pmem_address = owner ? data_mem_address : fetch_mem_address;
    assign pmem_wdata   = data_mem_wdata;

    assign fetch_mem_resp = busy && !owner && pmem_resp;
    assign data_mem_resp  = busy && owner && pmem_resp;

endmodule

`default_nettype wire

//--- design/fetch_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmem_defines.svh"

module fetch_line_buffer (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 fetch_read,
    input  pmem_pkg::addr_t      fetch_address,
    output pmem_pkg::word_t      fetch_rdata,
    output logic                 fetch_resp,

    output logic                 mem_read,
    output pmem_pkg::line_addr_t mem_address,
    input  pmem_pkg::line_t      mem_rdata,
    input  logic                 mem_resp,

    input  logic                 snoop_write,
    input  pmem_pkg::line_addr_t snoop_address
);
    import pmem_pkg::*;

    line_t      line_q;
    line_addr_t tag_q;
    logic       valid_q;
    line_addr_t req_line;
    word_sel_t  req_sel;
    logic       hit;
    logic       new_req;
    logic       fill;

    assign req_line = fetch_address[31:`PMEM_OFFSET_BITS];
    assign req_sel  = fetch_address[`PMEM_OFFSET_BITS-1:2];
    assign hit      = valid_q && (tag_q == req_line);

    // Held request already answered in the resp cycle
    assign new_req  = fetch_read && !fetch_resp && !mem_read;
    assign fill     = mem_read && mem_resp;

    assign mem_address = req_line;                      // Client holds the address

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            mem_read   <= 1'b0;
            fetch_resp <= 1'b0;
        end else begin
            fetch_resp <= 1'b0;
            if (fill) begin
                mem_read   <= 1'b0;
                valid_q    <= 1'b1;
                fetch_resp <= 1'b1;
            end else if (new_req) begin
                if (hit) begin
                    fetch_resp <= 1'b1;                 // Hit answers next cycle
                end else begin
                    mem_read <= 1'b1;
                end
            end
            // Drop the line when the data port writes it
            if (snoop_write && (snoop_address == tag_q)) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_q      <= mem_rdata;
            tag_q       <= mem_address;
            fetch_rdata <= mem_rdata[req_sel*32 +: 32];
        end else if (new_req && hit) begin
            fetch_rdata <= line_q[req_sel*32 +: 32];
        end
    end

endmodule

`default_nettype wire

//--- design/data_line_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmem_defines.svh"

module data_line_port (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 data_read,
    input  logic                 data_write,
    input  pmem_pkg::addr_t      data_address,
    input  pmem_pkg::word_t      data_wdata,
    input  pmem_pkg::byte_en_t   data_byte_enable,
    output pmem_pkg::word_t      data_rdata,
    output logic                 data_resp,

    output logic                 mem_read,
    output logic                 mem_write,
    output pmem_pkg::line_addr_t mem_address,
    output pmem_pkg::line_t      mem_wdata,
    input  pmem_pkg::line_t      mem_rdata,
    input  logic                 mem_resp
);
    import pmem_pkg::*;

    client_state_t state;
    logic          store_op;
    word_sel_t     word_sel;
    word_t         read_word;
    word_t         merged_word;
    line_t         merged_line;
    line_t         wb_line;
    logic          new_req;

    assign word_sel  = data_address[`PMEM_OFFSET_BITS-1:2];
    assign read_word = mem_rdata[word_sel*32 +: 32];
    assign new_req   = (data_read || data_write) && !data_resp;

    // Only the enabled bytes of the addressed word change
    always_comb begin
        merged_word = read_word;
        for (int i = 0; i < 4; i++) begin
            if (data_byte_enable[i]) begin
                merged_word[8*i +: 8] = data_wdata[8*i +: 8];
            end
        end
        merged_line = mem_rdata;
        merged_line[word_sel*32 +: 32] = merged_word;
    end

    assign mem_read    = (state == client_wait_read);
    assign mem_write   = (state == client_wait_write);
    assign mem_address = data_address[31:`PMEM_OFFSET_BITS];
    assign mem_wdata   = wb_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= client_idle;
            store_op  <= 1'b0;
            data_resp <= 1'b0;
        end else begin
            data_resp <= 1'b0;
            case (state)
                client_idle: begin
                    if (new_req) begin
                        store_op <= data_write;
                        state    <= client_wait_read;   // Stores read the line first
                    end
                end
                client_wait_read: begin
                    if (mem_resp) begin
                        if (store_op) begin
                            state <= client_wait_write;
                        end else begin
                            data_resp <= 1'b1;
                            state     <= client_idle;
                        end
                    end
                end
                client_wait_write: begin
                    if (mem_resp) begin
                        data_resp <= 1'b1;
                        state     <= client_idle;
                    end
                end
                default: state <= client_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == client_wait_read) && mem_resp) begin
            if (store_op) begin
                wb_line <= merged_line;                 // Held through the write
            end else begin
                data_rdata <= read_word;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               fetch_read,
    input  pmem_pkg::addr_t    fetch_address,
    output pmem_pkg::word_t    fetch_rdata,
    output logic               fetch_resp,

    input  logic               data_read,
    input  logic               data_write,
    input  pmem_pkg::addr_t    data_address,
    input  pmem_pkg::word_t    data_wdata,
    input  pmem_pkg::byte_en_t data_byte_enable,
    output pmem_pkg::word_t    data_rdata,
    output logic               data_resp,

    output logic               pmem_error
);
    import pmem_pkg::*;

    logic       fetch_mem_read;
    line_addr_t fetch_mem_address;
    logic       fetch_mem_resp;

    logic       data_mem_read;
    logic       data_mem_write;
    line_addr_t data_mem_address;
    line_t      data_mem_wdata;
    logic       data_mem_resp;

    logic       pmem_read;
    logic       pmem_write;
    line_addr_t pmem_address;
    line_t      pmem_wdata;
    line_t      pmem_rdata;                             // Shared by both clients
    logic       pmem_resp;

    fetch_line_buffer u_fetch_line_buffer (
        .clk           (clk),
        .reset         (reset),
        .fetch_read    (fetch_read),
        .fetch_address (fetch_address),
        .fetch_rdata   (fetch_rdata),
        .fetch_resp    (fetch_resp),
        .mem_read      (fetch_mem_read),
        .mem_address   (fetch_mem_address),
        .mem_rdata     (pmem_rdata),
        .mem_resp      (fetch_mem_resp),
        .snoop_write   (pmem_write),
        .snoop_address (pmem_address)
    );

    data_line_port u_data_line_port (
        .clk              (clk),
        .reset            (reset),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_address     (data_address),
        .data_wdata       (data_wdata),
        .data_byte_enable (data_byte_enable),
        .data_rdata       (data_rdata),
        .data_resp        (data_resp),
        .mem_read         (data_mem_read),
        .mem_write        (data_mem_write),
        .mem_address      (data_mem_address),
        .mem_wdata        (data_mem_wdata),
        .mem_rdata        (pmem_rdata),
        .mem_resp         (data_mem_resp)
    );

    pmem_arbiter u_pmem_arbiter (
        .clk               (clk),
        .reset             (reset),
        .fetch_mem_read    (fetch_mem_read),
        .fetch_mem_address (fetch_mem_address),
        .fetch_mem_resp    (fetch_mem_resp),
        .data_mem_read     (data_mem_read),
        .data_mem_write    (data_mem_write),
        .data_mem_address  (data_mem_address),
        .data_mem_wdata    (data_mem_wdata),
        .data_mem_resp     (data_mem_resp),
        .pmem_read         (pmem_read),
        .pmem_write        (pmem_write),
        .pmem_address      (pmem_address),
        .pmem_wdata        (pmem_wdata),
        .pmem_resp         (pmem_resp)
    );

    phys_mem_model u_phys_mem_model (
        .clk     (clk),
        .reset   (reset),
        .read    (pmem_read),
        .write   (pmem_write),
        .address (pmem_address),
        .wdata   (pmem_wdata),
        .resp    (pmem_resp),
        .error   (pmem_error),
        .rdata   (pmem_rdata)
    );

endmodule

`default_nettype wire

//--- verification/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmem_defines.svh"

module mem_subsystem_tb;
    import pmem_pkg::*;

    localparam int    clk_period   = 40;
    localparam int    reset_cycles = 10;
    localparam int    seed         = 37660;
    localparam int    directed_ops = 64;
    localparam int    random_ops   = 48;                     // Per client
    localparam int    txn_cycles   = 3 * (`PMEM_DELAY + 8);  // Three memory trips plus slack
    localparam int    watchdog_ns  =
        (reset_cycles + (directed_ops + 2 * random_ops) * txn_cycles) * clk_period;
    localparam addr_t region_base  = 32'h0000_1000;          // Four lines shared in random phase

    logic     clk = 1'b0;
    logic     reset;
    logic     fetch_read;
    addr_t    fetch_address;
    word_t    fetch_rdata;
    logic     fetch_resp;
    logic     data_read;
    logic     data_write;
    addr_t    data_address;
    word_t    data_wdata;
    byte_en_t data_byte_enable;
    word_t    data_rdata;
    logic     data_resp;
    logic     pmem_error;

    word_t    shadow [logic [29:0]];                         // Word-addressed
    string    check_name [$];
    word_t    check_expected [$];
    word_t    check_actual [$];
    logic     fetch_resp_prev;
    logic     data_resp_prev;

    logic     rnd_store [random_ops];
    addr_t    rnd_data_addr [random_ops];
    word_t    rnd_wdata [random_ops];
    byte_en_t rnd_be [random_ops];
    addr_t    rnd_fetch_addr [random_ops];

    mem_subsystem_top u_mem_subsystem_top (
        .clk              (clk),
        .reset            (reset),
        .fetch_read       (fetch_read),
        .fetch_address    (fetch_address),
        .fetch_rdata      (fetch_rdata),
        .fetch_resp       (fetch_resp),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_address     (data_address),
        .data_wdata       (data_wdata),
        .data_byte_enable (data_byte_enable),
        .data_rdata       (data_rdata),
        .data_resp        (data_resp),
        .pmem_error       (pmem_error)
    );

    always #(clk_period / 2) clk = ~clk;

    // Expected word at an address; a store merges its enabled bytes first
    function automatic word_t reference_word(input addr_t address, input logic store,
                                             input word_t wdata, input byte_en_t be);
        word_t value;
        value = shadow.exists(address[31:2]) ? shadow[address[31:2]] : '0;
        if (store) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    value[8*i +: 8] = wdata[8*i +: 8];
                end
            end
            shadow[address[31:2]] = value;
        end
        return value;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compare_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic record_result(input string name, input word_t expected, input word_t actual);
        check_name.push_back(name);
        check_expected.push_back(expected);
        check_actual.push_back(actual);
    endtask

    task automatic fetch_word(input addr_t address, output word_t rdata, output int cycles);
        fetch_read    = 1'b1;
        fetch_address = address;
        cycles        = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!fetch_resp);
        rdata      = fetch_rdata;
        fetch_read = 1'b0;                                   // Drop in the cycle after resp
        @(negedge clk);
    endtask

    task automatic data_access(input logic store, input addr_t address, input word_t wdata,
                               input byte_en_t be, output word_t rdata);
        data_read        = !store;
        data_write       = store;
        data_address     = address;
        data_wdata       = wdata;
        data_byte_enable = be;
        do begin
            @(negedge clk);
        end while (!data_resp);
        rdata      = data_rdata;
        data_read  = 1'b0;
        data_write = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetch_and_check(input addr_t address, input logic expect_hit);
        word_t value;
        int    cycles;
        fetch_word(address, value, cycles);
        record_result("fetch_rdata", reference_word(address, 1'b0, '0, '0), value);
        if (expect_hit) begin
            record_result("fetch_resp latency", 32'd1, word_t'(cycles));
        end
    endtask

    task automatic load_and_check(input addr_t address);
        word_t value;
        data_access(1'b0, address, '0, '0, value);
        record_result("data_rdata", reference_word(address, 1'b0, '0, '0), value);
    endtask

    task automatic store_word(input addr_t address, input word_t wdata, input byte_en_t be);
        word_t unused;
        data_access(1'b1, address, wdata, be, unused);
        void'(reference_word(address, 1'b1, wdata, be));
    endtask

    // Compares queued results and watches error and resp pulse width
    always @(negedge clk) begin
        while (check_name.size() != 0) begin
            compare_value(check_name.pop_front(), check_expected.pop_front(),
                          check_actual.pop_front());
        end
        if (!reset) begin
            compare_value("pmem_error", '0, {31'b0, pmem_error});
            if ((fetch_resp && fetch_resp_prev) || (data_resp && data_resp_prev)) begin
                stop_run("A resp signal stayed high for more than one cycle");
            end
        end
        fetch_resp_prev = fetch_resp;
        data_resp_prev  = data_resp;
    end

    initial begin
        #(watchdog_ns);
        stop_run("Watchdog timeout: requests did not complete in time");
    end

    initial begin
        addr_t address;
        int    line_idx;
        int    slot;
        void'($urandom(seed));
        reset            = 1'b1;
        fetch_read       = 1'b0;
        fetch_address    = '0;
        data_read        = 1'b0;
        data_write       = 1'b0;
        data_address     = '0;
        data_wdata       = '0;
        data_byte_enable = '0;
        for (int i = 0; i < random_ops; i++) begin
            rnd_store[i]      = ($urandom_range(1) == 1);
            line_idx          = int'($urandom_range(3));
            slot              = rnd_store[i] ? int'(2 * $urandom_range(3)) : int'($urandom_range(7));
            rnd_data_addr[i]  = region_base + addr_t'(line_idx * 32 + slot * 4);
            rnd_wdata[i]      = $urandom;
            rnd_be[i]         = byte_en_t'($urandom_range(15, 1));
            line_idx          = int'($urandom_range(3));
            slot              = int'(2 * $urandom_range(3) + 1);     // Odd words only
            rnd_fetch_addr[i] = region_base + addr_t'(line_idx * 32 + slot * 4);
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fetch_and_check(32'h0000_0040, 1'b0);                  // Untouched, reads zero
        load_and_check(32'h0000_0084);

        for (int i = 0; i < 8; i++) begin
            address = 32'h0000_0200 + addr_t'($urandom_range(3) * 4);
            store_word(address, $urandom, byte_en_t'($urandom_range(15)));
            load_and_check(address);
        end

        // Line fetched, stored by the data port, fetched again
        fetch_and_check(32'h0000_0304, 1'b0);
        store_word(32'h0000_0304, $urandom | 32'h1, 4'hf);
        fetch_and_check(32'h0000_0304, 1'b0);

        for (int w = 0; w < 8; w++) begin
            store_word(32'h0000_0400 + addr_t'(w * 4), $urandom, 4'hf);
        end
        fetch_and_check(32'h0000_0400, 1'b0);                  // Miss fills the buffer
        for (int w = 7; w >= 0; w--) begin
            fetch_and_check(32'h0000_0400 + addr_t'(w * 4), 1'b1);
        end

        for (int i = 0; i < 16; i++) begin
            store_word(region_base + addr_t'((i / 4) * 32 + (2 * (i % 4) + 1) * 4),
                       $urandom, 4'hf);
        end

        // Both clients at once; data stores even words, fetch reads odd words
        fork
            begin
                for (int i = 0; i < random_ops; i++) begin
                    if (rnd_store[i]) begin
                        store_word(rnd_data_addr[i], rnd_wdata[i], rnd_be[i]);
                    end else begin
                        load_and_check(rnd_data_addr[i]);
                    end
                end
            end
            begin
                for (int i = 0; i < random_ops; i++) begin
                    fetch_and_check(rnd_fetch_addr[i], 1'b0);
                end
            end
        join

        while (check_name.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/pmem_pkg.sv
design/phys_mem_model.sv
design/pmem_arbiter.sv
design/fetch_line_buffer.sv
design/data_line_port.sv
design/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module mem_subsystem_tb \
    -f filelist.f -Mdir obj_dir -o mem_subsystem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0
